// ==== verilog/kin_types_pkg.sv ====
/*
 * fixed-point, angle and matrix types for the kinematics datapath
 * DH parameter record and per-arm parameter set
 * joint count and fraction constants
 */
package kin_types_pkg;

	localparam int FIX_W      = 18;
	localparam int FRAC_BITS  = 14;
	localparam int WIDE_W     = 38; // holds four 36-bit products
	localparam int ANGLE_W    = 6;
	localparam int JIDX_W     = 3;
	localparam int NUM_JOINTS = 6;
	localparam int FIX_ONE    = 16384; // 1.0 in Q3.14

	// signed Q3.14
	typedef logic signed [FIX_W-1:0] fix_t;

	// product and sum width inside the multipliers
	typedef logic signed [WIDE_W-1:0] wide_t;

	// fraction of a turn, 64 steps
	typedef logic [ANGLE_W-1:0] angle_t;

	typedef logic [JIDX_W-1:0] jidx_t;

	// one joint, 48 bits
	typedef struct packed {
		angle_t theta;
		angle_t alpha;
		fix_t   a;
		fix_t   d;
	} dh_param_t;

	typedef dh_param_t [NUM_JOINTS-1:0] dh_set_t;

	// row then column
	typedef fix_t [3:0][3:0] mat4_t;

endpackage

// ==== verilog/kin_trig_pkg.sv ====
/*
 * quarter-wave sine table, Q3.14
 * angle field split into quadrant and remainder
 */
package kin_trig_pkg;

	localparam int QUAD_BITS = 2;  // top bits of an angle
	localparam int REM_BITS  = 4;  // index within a quadrant
	localparam int QUARTER   = 16; // steps per quarter turn

	// entry k is round(16384 * sin(k * pi/32))
	localparam kin_types_pkg::fix_t SIN_TABLE [0:QUARTER] = '{
		18'sd0,
		18'sd1606,
		18'sd3196,
		18'sd4756,
		18'sd6270,
		18'sd7723,
		18'sd9102,
		18'sd10394,
		18'sd11585,
		18'sd12665,
		18'sd13623,
		18'sd14449,
		18'sd15137,
		18'sd15679,
		18'sd16069,
		18'sd16305,
		18'sd16384
	};

endpackage

// ==== verilog/sincos_lut.sv ====
/*
 * registered sine and cosine of one angle
 * quarter-wave folding into the shared table
 */
`timescale 1ns/100ps

module sincos_lut (
	input  logic                 i,
	input  logic                 rst_n,
	input  kin_types_pkg::angle_t angle,
	output kin_types_pkg::fix_t  sin_val,
	output kin_types_pkg::fix_t  cos_val
);

	// quadrant picks direction and sign of the table walk
	function automatic kin_types_pkg::fix_t fold_sin(input kin_types_pkg::angle_t ang);
		logic [kin_trig_pkg::QUAD_BITS-1:0] q;
		logic [kin_trig_pkg::REM_BITS:0]    idx;
		kin_types_pkg::fix_t                mag;
		q   = ang[kin_types_pkg::ANGLE_W-1 -: kin_trig_pkg::QUAD_BITS];
		idx = {1'b0, ang[kin_trig_pkg::REM_BITS-1:0]};
		if (q[0])
			idx = (kin_trig_pkg::REM_BITS+1)'(kin_trig_pkg::QUARTER) - idx; // falling half
		mag = kin_trig_pkg::SIN_TABLE[idx];
		return q[1] ? -mag : mag;
	endfunction

	kin_types_pkg::angle_t cos_angle;

	assign cos_angle = angle + kin_types_pkg::angle_t'(kin_trig_pkg::QUARTER); // wraps mod 64

	always_ff @(posedge i) begin
		if (!rst_n) begin
			sin_val <= '0;
			cos_val <= kin_types_pkg::fix_t'(kin_types_pkg::FIX_ONE); // angle 0
		end else begin
			sin_val <= fold_sin(angle);
			cos_val <= fold_sin(cos_angle);
		end
	end

endmodule

// ==== verilog/dh_transform.sv ====
/*
 * one joint's homogeneous transform from its DH parameters
 * trig lookup stage then product stage, two cycles
 */
`timescale 1ns/100ps

module dh_transform (
	input  logic                    i,
	input  logic                    rst_n,
	input  kin_types_pkg::dh_param_t joint,
	input  logic                    joint_valid,
	output kin_types_pkg::mat4_t    xform,
	output logic                    xform_valid
);

	// full product, shift once, keep low 18 bits
	function automatic kin_types_pkg::fix_t fix_mul(
		input kin_types_pkg::fix_t x,
		input kin_types_pkg::fix_t y
	);
		kin_types_pkg::wide_t p;
		p = kin_types_pkg::wide_t'(x) * kin_types_pkg::wide_t'(y);
		return kin_types_pkg::fix_t'(p >>> kin_types_pkg::FRAC_BITS);
	endfunction

	kin_types_pkg::fix_t sin_th, cos_th, sin_al, cos_al;
	kin_types_pkg::fix_t a_q, d_q; // aligned with the trig outputs
	logic                valid_q;

	sincos_lut u_theta_lut (
		.i       (i),
		.rst_n   (rst_n),
		.angle   (joint.theta),
		.sin_val (sin_th),
		.cos_val (cos_th)
	);

	sincos_lut u_alpha_lut (
		.i       (i),
		.rst_n   (rst_n),
		.angle   (joint.alpha),
		.sin_val (sin_al),
		.cos_val (cos_al)
	);

	always_ff @(posedge i) begin
		a_q <= joint.a;
		d_q <= joint.d;
		xform[0] <= {fix_mul(a_q, cos_th), fix_mul(sin_th, sin_al),
			-fix_mul(sin_th, cos_al), cos_th}; // row 0, column 3 first
		xform[1] <= {fix_mul(a_q, sin_th), -fix_mul(cos_th, sin_al),
			fix_mul(cos_th, cos_al), sin_th};
		xform[2] <= {d_q, cos_al, sin_al, kin_types_pkg::fix_t'(0)};
		xform[3] <= {kin_types_pkg::fix_t'(kin_types_pkg::FIX_ONE), {3{kin_types_pkg::fix_t'(0)}}};
	end

	always_ff @(posedge i) begin
		if (!rst_n) begin
			valid_q     <= 1'b0;
			xform_valid <= 1'b0;
		end else begin
			valid_q     <= joint_valid;
			xform_valid <= valid_q;
		end
	end

endmodule

// ==== verilog/mat4_mult.sv ====
/*
 * running pose accumulator, acc <= acc * xform
 * all 64 products and 16 sums in one cycle
 */
`timescale 1ns/100ps

module mat4_mult (
	input  logic                 i,
	input  logic                 rst_n,
	input  logic                 clear,
	input  kin_types_pkg::mat4_t xform,
	input  logic                 xform_valid,
	output kin_types_pkg::mat4_t acc
);

	function automatic kin_types_pkg::mat4_t identity();
		kin_types_pkg::mat4_t m;
		m = '0;
		for (int k = 0; k < 4; k++)
			m[k][k] = kin_types_pkg::fix_t'(kin_types_pkg::FIX_ONE);
		return m;
	endfunction

	// sums kept wide, one shift per element
	function automatic kin_types_pkg::mat4_t mat_mul(
		input kin_types_pkg::mat4_t x,
		input kin_types_pkg::mat4_t y
	);
		kin_types_pkg::mat4_t m;
		kin_types_pkg::wide_t sum;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				sum = '0;
				for (int k = 0; k < 4; k++)
					sum += kin_types_pkg::wide_t'($signed(x[r][k]))
						* kin_types_pkg::wide_t'($signed(y[k][c]));
				m[r][c] = kin_types_pkg::fix_t'(sum >>> kin_types_pkg::FRAC_BITS);
			end
		end
		return m;
	endfunction

	kin_types_pkg::mat4_t prod;

	assign prod = mat_mul(acc, xform);

	always_ff @(posedge i) begin
		if (!rst_n)
			acc <= identity();
		else if (clear)
			acc <= identity(); // new run starts from the base frame
		else if (xform_valid)
			acc <= prod;
	end

endmodule

// ==== verilog/kin_sequencer.sv ====
/*
 * run control for one forward-kinematics pass
 * captures the set, issues six joints, counts the returns
 */
`timescale 1ns/100ps

module kin_sequencer (
	input  logic                    i,
	input  logic                    rst_n,
	input  logic                    start,
	input  kin_types_pkg::dh_set_t  params,
	output kin_types_pkg::dh_param_t joint,
	output logic                    joint_valid,
	output logic                    clear,
	input  logic                    xform_valid,
	output logic                    busy,
	output logic                    done
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		DRAIN,
		FINISH
	} state_t;

	state_t                 state;
	kin_types_pkg::dh_set_t set_q;
	kin_types_pkg::jidx_t   issue_cnt;
	kin_types_pkg::jidx_t   ret_cnt;  // transforms seen this run
	logic                   accept;

	assign accept = start && !busy; // FINISH takes a start as well
	assign busy   = (state == ISSUE) || (state == DRAIN);
	assign done   = (state == FINISH);

	always_ff @(posedge i) begin
		if (!rst_n) begin
			state       <= IDLE;
			issue_cnt   <= '0;
			ret_cnt     <= '0;
			joint_valid <= 1'b0;
			clear       <= 1'b0;
		end else begin
			joint_valid <= 1'b0;
			clear       <= accept;
			if (xform_valid)
				ret_cnt <= ret_cnt + 1'b1;
			case (state)
				IDLE, FINISH: begin
					state <= IDLE;
					if (accept) begin
						state     <= ISSUE;
						issue_cnt <= '0;
						ret_cnt   <= '0;
					end
				end
				ISSUE: begin
					joint_valid <= 1'b1;
					issue_cnt   <= issue_cnt + 1'b1;
					if (issue_cnt == kin_types_pkg::jidx_t'(kin_types_pkg::NUM_JOINTS - 1))
						state <= DRAIN;
				end
				DRAIN: begin
					if (xform_valid
						&& ret_cnt == kin_types_pkg::jidx_t'(kin_types_pkg::NUM_JOINTS - 1))
						state <= FINISH; // accumulator takes the last update on this edge
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (accept)
			set_q <= params;
		if (state == ISSUE)
			joint <= set_q[issue_cnt];
	end

endmodule

// ==== verilog/fwd_kin_top.sv ====
/*
 * forward kinematics top
 * sequencer, DH transform and pose accumulator
 */
`timescale 1ns/100ps

module fwd_kin_top (
	input  logic                   i,
	input  logic                   rst_n,
	input  logic                   start,
	input  kin_types_pkg::dh_set_t params,
	output logic                   busy,
	output logic                   done,
	output kin_types_pkg::mat4_t   pose
);

	kin_types_pkg::dh_param_t joint;
	logic                     joint_valid;
	logic                     clear;
	kin_types_pkg::mat4_t     xform;
	logic                     xform_valid;

	kin_sequencer u_kin_sequencer (
		.i           (i),
		.rst_n       (rst_n),
		.start       (start),
		.params      (params),
		.joint       (joint),
		.joint_valid (joint_valid),
		.clear       (clear),
		.xform_valid (xform_valid),
		.busy        (busy),
		.done        (done)
	);

	dh_transform u_dh_transform (
		.i           (i),
		.rst_n       (rst_n),
		.joint       (joint),
		.joint_valid (joint_valid),
		.xform       (xform),
		.xform_valid (xform_valid)
	);

	// pose is the accumulator itself
	mat4_mult u_mat4_mult (
		.i           (i),
		.rst_n       (rst_n),
		.clear       (clear),
		.xform       (xform),
		.xform_valid (xform_valid),
		.acc         (pose)
	);

endmodule

// ==== sim/fwd_kin_ref.svh ====
/*
 * Galois LFSR step for random stimulus
 * reference sine, cosine, joint transform, matrix product and joint chain
 */
`ifndef FWD_KIN_REF_SVH
`define FWD_KIN_REF_SVH

// taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

// quadrant and remainder walk over the quarter-wave table
function automatic kin_types_pkg::fix_t ref_sin(input int ang);
	int q;
	int r;
	q = (ang % 64) / 16;
	r = ang % 16;
	case (q)
		0: return kin_trig_pkg::SIN_TABLE[r];
		1: return kin_trig_pkg::SIN_TABLE[16 - r];
		2: return -kin_trig_pkg::SIN_TABLE[r];
		default: return -kin_trig_pkg::SIN_TABLE[16 - r];
	endcase
endfunction

function automatic kin_types_pkg::fix_t ref_cos(input int ang);
	return ref_sin((ang + 16) % 64); // quarter turn ahead
endfunction

function automatic kin_types_pkg::fix_t ref_mul(
	input kin_types_pkg::fix_t x,
	input kin_types_pkg::fix_t y
);
	longint p;
	p = longint'(x) * longint'(y);
	return kin_types_pkg::fix_t'(p >>> kin_types_pkg::FRAC_BITS);
endfunction

function automatic kin_types_pkg::mat4_t ref_identity();
	kin_types_pkg::mat4_t m;
	m = '0;
	for (int k = 0; k < 4; k++)
		m[k][k] = kin_types_pkg::fix_t'(kin_types_pkg::FIX_ONE);
	return m;
endfunction

function automatic kin_types_pkg::mat4_t ref_joint(input kin_types_pkg::dh_param_t jp);
	kin_types_pkg::mat4_t m;
	kin_types_pkg::fix_t  st, ct, sa, ca;
	st = ref_sin(int'(jp.theta));
	ct = ref_cos(int'(jp.theta));
	sa = ref_sin(int'(jp.alpha));
	ca = ref_cos(int'(jp.alpha));
	m = '0;
	m[0][0] = ct;
	m[0][1] = -ref_mul(st, ca); // negated after the shift
	m[0][2] = ref_mul(st, sa);
	m[0][3] = ref_mul(jp.a, ct);
	m[1][0] = st;
	m[1][1] = ref_mul(ct, ca);
	m[1][2] = -ref_mul(ct, sa);
	m[1][3] = ref_mul(jp.a, st);
	m[2][1] = sa;
	m[2][2] = ca;
	m[2][3] = jp.d;
	m[3][3] = kin_types_pkg::fix_t'(kin_types_pkg::FIX_ONE);
	return m;
endfunction

// four products summed wide, one shift per element
function automatic kin_types_pkg::mat4_t ref_mat_mul(
	input kin_types_pkg::mat4_t x,
	input kin_types_pkg::mat4_t y
);
	kin_types_pkg::mat4_t m;
	longint               sum;
	for (int r = 0; r < 4; r++) begin
		for (int c = 0; c < 4; c++) begin
			sum = 0;
			for (int k = 0; k < 4; k++)
				sum += longint'($signed(x[r][k])) * longint'($signed(y[k][c]));
			m[r][c] = kin_types_pkg::fix_t'(sum >>> kin_types_pkg::FRAC_BITS);
		end
	end
	return m;
endfunction

function automatic kin_types_pkg::mat4_t ref_chain(input kin_types_pkg::dh_set_t s);
	kin_types_pkg::mat4_t acc;
	acc = ref_identity();
	for (int j = 0; j < kin_types_pkg::NUM_JOINTS; j++)
		acc = ref_mat_mul(acc, ref_joint(s[j])); // base to tool order
	return acc;
endfunction

`endif

// ==== sim/fwd_kin_tb.sv ====
/*
 * forward kinematics testbench
 * directed and random DH sets checked against the reference chain
 */
`timescale 1ns/100ps

module fwd_kin_tb;

	localparam int DONE_TIMEOUT = 50; // cycles
	localparam int LATENCY      = 9;
	localparam int QUAD_COS [3] = '{0, -kin_types_pkg::FIX_ONE, 0};
	localparam int QUAD_SIN [3] = '{kin_types_pkg::FIX_ONE, 0, -kin_types_pkg::FIX_ONE};

	logic                   i;
	logic                   rst_n;
	logic                   start;
	kin_types_pkg::dh_set_t params;
	logic                   busy;
	logic                   done;
	kin_types_pkg::mat4_t   pose;

	int                   cyc = 0;
	int                   launched = 0;
	int                   done_count = 0;
	logic [15:0]          lfsr_state = 16'd29;
	kin_types_pkg::mat4_t exp_q[$];
	string                name_q[$];
	int                   start_q[$]; // edge that sampled each start

	`include "fwd_kin_ref.svh"

	fwd_kin_top u_fwd_kin_top (
		.i      (i),
		.rst_n  (rst_n),
		.start  (start),
		.params (params),
		.busy   (busy),
		.done   (done),
		.pose   (pose)
	);

	always #50 i = ~i;

	always @(posedge i) cyc <= cyc + 1;

	task automatic abort_test(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic signed [63:0] expected,
		input logic signed [63:0] actual);
		if (expected !== actual)
			abort_test($sformatf("Mismatch %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	task automatic check_pose(input string name, input kin_types_pkg::mat4_t expected);
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				check_value($sformatf("%s pose[%0d][%0d]", name, r, c),
					64'($signed(expected[r][c])), 64'($signed(pose[r][c])));
	endtask

	// one LFSR step per bit
	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic random_set(output kin_types_pkg::dh_set_t jset);
		logic [15:0] v;
		for (int j = 0; j < kin_types_pkg::NUM_JOINTS; j++) begin
			take_bits(6, v);
			jset[j].theta = v[5:0];
			take_bits(6, v);
			jset[j].alpha = v[5:0];
			take_bits(14, v);
			jset[j].a = kin_types_pkg::fix_t'($signed(v[13:0])); // within +-0.5
			take_bits(14, v);
			jset[j].d = kin_types_pkg::fix_t'($signed(v[13:0]));
		end
	endtask

	// called on a rising edge, returns on the edge that samples start
	task automatic launch_run(input string name, input kin_types_pkg::dh_set_t jset,
		input kin_types_pkg::mat4_t expected);
		start  <= 1'b1;
		params <= jset;
		@(posedge i);
		start <= 1'b0;
		exp_q.push_back(expected);
		name_q.push_back(name);
		start_q.push_back(cyc + 1);
		launched++;
	endtask

	task automatic wait_for_done();
		int n;
		for (n = 0; n < DONE_TIMEOUT; n++) begin
			@(posedge i);
			if (done_count >= launched)
				break;
		end
		if (done_count < launched)
			abort_test("timeout: done never arrived after start");
	endtask

	// every done is matched to the oldest pending run
	always @(negedge i) begin
		logic busy_exp;
		if (rst_n) begin
			busy_exp = 1'b0; // high from the start edge until done
			if (exp_q.size() != 0)
				busy_exp = (cyc - start_q[0]) < LATENCY;
			check_value("busy level", 64'(busy_exp), 64'(busy));
			if (done) begin
				if (exp_q.size() == 0)
					abort_test("done pulsed with no run pending");
				else begin
					check_pose(name_q[0], exp_q[0]);
					check_value({name_q[0], " latency"}, 64'(LATENCY), 64'(cyc - start_q[0]));
					void'(exp_q.pop_front());
					void'(name_q.pop_front());
					void'(start_q.pop_front());
					done_count++;
				end
			end
		end
	end

	initial begin
		kin_types_pkg::dh_set_t jset;
		kin_types_pkg::mat4_t   m;
		kin_types_pkg::fix_t    dsum;
		i      = 1'b0;
		rst_n  = 1'b0;
		start  = 1'b0;
		params = '0;
		repeat (4) @(posedge i);
		rst_n <= 1'b1;
		@(negedge i);
		check_value("reset busy", 64'(0), 64'(busy));
		check_value("reset done", 64'(0), 64'(done));
		check_pose("reset", ref_identity());
		@(posedge i);

		jset = '0;
		launch_run("all zero", jset, ref_identity());
		wait_for_done();
		dsum = '0;
		for (int j = 0; j < kin_types_pkg::NUM_JOINTS; j++) begin
			jset[j].d = kin_types_pkg::fix_t'((j - 2) * 1500); // mixed signs
			dsum = dsum + jset[j].d;
		end
		m = ref_identity();
		m[2][3] = dsum;
		launch_run("d only", jset, m);
		wait_for_done();

		// quarter, half and three-quarter turns on joint 0
		for (int n = 0; n < 3; n++) begin
			jset = '0;
			jset[0].theta = kin_types_pkg::angle_t'(16 * (n + 1));
			jset[0].alpha = kin_types_pkg::angle_t'(16 * (n + 1));
			launch_run($sformatf("quadrant %0d", 16 * (n + 1)), jset, ref_chain(jset));
			wait_for_done();
			@(negedge i);
			check_value("quadrant cos theta", 64'(QUAD_COS[n]), 64'($signed(pose[0][0])));
			check_value("quadrant sin theta", 64'(QUAD_SIN[n]), 64'($signed(pose[1][0])));
			check_value("quadrant sin alpha", 64'(QUAD_SIN[n]), 64'($signed(pose[2][1])));
			check_value("quadrant cos alpha", 64'(QUAD_COS[n]), 64'($signed(pose[2][2])));
			@(posedge i);
		end

		// each run starts the cycle after the previous done
		for (int n = 0; n < 20; n++) begin
			random_set(jset);
			launch_run($sformatf("random %0d", n), jset, ref_chain(jset));
			wait_for_done();
		end

		random_set(jset);
		launch_run("start while busy", jset, ref_chain(jset));
		repeat (3) @(posedge i);
		random_set(jset);
		start  <= 1'b1; // second set must be ignored
		params <= jset;
		@(posedge i);
		start <= 1'b0;
		wait_for_done();
		repeat (20) @(posedge i); // window for a stray second done

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== build.f ====
verilog/kin_types_pkg.sv
verilog/kin_trig_pkg.sv
verilog/sincos_lut.sv
verilog/dh_transform.sv
verilog/mat4_mult.sv
verilog/kin_sequencer.sv
verilog/fwd_kin_top.sv
sim/fwd_kin_tb.sv
+incdir+sim

// ==== Makefile ====
# Verilator build and run of the forward kinematics testbench

VERILATOR ?= verilator
TOP       ?= fwd_kin_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing -j 0
PASS_LINE ?= RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_LINE)"

clean:
	rm -rf $(OBJ_DIR)
